/* include/noc_settings.svh */
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// mesh dimensions.
`define NOC_SIZE_X 4
`define NOC_SIZE_Y 4

// one bit wider than the mesh needs, so bad destinations can be encoded.
`define NOC_COORD_W 3

// virtual channels per router input.
`define NOC_VCS 2

// payload bits carried by every flit.
`define NOC_DATA_W 16

`endif

/* hdl/noc_flit_pkg.sv */
`default_nettype none

`include "noc_settings.svh"

package noc_flit_pkg;

  // mesh coordinate.
  typedef struct packed {
    logic [`NOC_COORD_W-1:0] x;
    logic [`NOC_COORD_W-1:0] y;
  } noc_location;

  // routing header of a head flit.
  typedef struct packed {
    noc_location destination;
    logic        invalid_destination;
  } noc_header;

  // header is only meaningful while head is set.
  // a single-flit packet carries both head and tail.
  typedef struct packed {
    logic                   head;
    logic                   tail;
    noc_header              header;
    logic [`NOC_DATA_W-1:0] data;
  } noc_flit;

endpackage

`default_nettype wire

/* hdl/noc_route_pkg.sv */
`default_nettype none

`include "noc_settings.svh"

package noc_route_pkg;

  // output ports of one router.
  localparam int NOC_PORTS = 5;

  // one-hot output port selection.
  typedef enum logic [NOC_PORTS-1:0] {
    ROUTE_NONE    = 5'b00000,
    ROUTE_X_PLUS  = 5'b00001,
    ROUTE_X_MINUS = 5'b00010,
    ROUTE_Y_PLUS  = 5'b00100,
    ROUTE_Y_MINUS = 5'b01000,
    ROUTE_LOCAL   = 5'b10000
  } noc_route;

  // per-VC strobes seen by one output port.
  typedef struct packed {
    logic [`NOC_VCS-1:0] request;
    logic [`NOC_VCS-1:0] start_of_packet;
    logic [`NOC_VCS-1:0] end_of_packet;
  } noc_port_request;

endpackage

`default_nettype wire

/* hdl/noc_route_selector.sv */
`default_nettype none

`include "noc_settings.svh"

module noc_route_selector #(
  parameter int       X               = 0,
  parameter int       Y               = 0,
  parameter bit [4:0] available_ports = 5'b11111
) (
  input  logic                                                   clk,
  input  logic                                                   rst_n,
  input  noc_flit_pkg::noc_flit [`NOC_VCS-1:0]                   flit_in,
  input  logic [`NOC_VCS-1:0]                                    flit_in_valid,
  output logic [`NOC_VCS-1:0]                                    flit_in_ready,
  output noc_route_pkg::noc_port_request [4:0]                   port_req,
  output noc_flit_pkg::noc_flit [4:0][`NOC_VCS-1:0]              routed_flit,
  output logic [4:0][`NOC_VCS-1:0]                               routed_valid,
  input  logic [4:0][`NOC_VCS-1:0]                               grant,
  input  logic [4:0][`NOC_VCS-1:0]                               vc_ready
);

  noc_route_pkg::noc_route route_next [`NOC_VCS];
  noc_route_pkg::noc_route route_q    [`NOC_VCS];
  noc_route_pkg::noc_route route      [`NOC_VCS];

  logic [`NOC_VCS-1:0]                 start_of_packet;
  logic [`NOC_VCS-1:0]                 end_of_packet;
  logic [`NOC_VCS-1:0]                 tail;
  noc_flit_pkg::noc_flit [`NOC_VCS-1:0] flit_marked;

  // xy order; a disabled port falls back to local.
  function automatic noc_route_pkg::noc_route select_route(
    input noc_flit_pkg::noc_flit flit
  );
    noc_flit_pkg::noc_location dst;
    dst = flit.header.destination;
    case (1'b1)
      (dst.x > X) && available_ports[0]: return noc_route_pkg::ROUTE_X_PLUS;
      (dst.x < X) && available_ports[1]: return noc_route_pkg::ROUTE_X_MINUS;
      (dst.y > Y) && available_ports[2]: return noc_route_pkg::ROUTE_Y_PLUS;
      (dst.y < Y) && available_ports[3]: return noc_route_pkg::ROUTE_Y_MINUS;
      default:                           return noc_route_pkg::ROUTE_LOCAL;
    endcase
  endfunction

  // flag head flits aimed outside the mesh.
  function automatic noc_flit_pkg::noc_flit mark_destination(
    input noc_flit_pkg::noc_flit flit
  );
    noc_flit_pkg::noc_flit     result;
    noc_flit_pkg::noc_location dst;
    result = flit;
    dst    = flit.header.destination;
    if (flit.head && ((dst.x >= `NOC_SIZE_X) || (dst.y >= `NOC_SIZE_Y))) begin
      result.header.invalid_destination = 1'b1;
    end
    return result;
  endfunction

  always_comb begin
    for (int i = 0; i < `NOC_VCS; i++) begin
      start_of_packet[i] = flit_in_valid[i] && flit_in[i].head;
      tail[i]            = flit_in[i].tail;
      route_next[i]      = select_route(flit_in[i]);
      flit_marked[i]     = mark_destination(flit_in[i]);
      // the head decides directly, later flits use the held route.
      if (start_of_packet[i]) begin
        route[i] = route_next[i];
      end else begin
        route[i] = route_q[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `NOC_VCS; i++) begin
        route_q[i] <= noc_route_pkg::ROUTE_NONE;
      end
    end else begin
      for (int i = 0; i < `NOC_VCS; i++) begin
        if (end_of_packet[i]) begin
          route_q[i] <= noc_route_pkg::ROUTE_NONE;
        end else if (start_of_packet[i]) begin
          route_q[i] <= route_next[i];
        end
      end
    end
  end

  // ready comes back from whichever port the VC points at.
  always_comb begin
    flit_in_ready = '0;
    for (int i = 0; i < `NOC_VCS; i++) begin
      for (int p = 0; p < noc_route_pkg::NOC_PORTS; p++) begin
        if (available_ports[p] && route[i][p] && vc_ready[p][i]) begin
          flit_in_ready[i] = 1'b1;
        end
      end
    end
  end

  assign end_of_packet = flit_in_valid & flit_in_ready & tail;

  always_comb begin
    port_req     = '0;
    routed_flit  = '0;
    routed_valid = '0;
    for (int p = 0; p < noc_route_pkg::NOC_PORTS; p++) begin
      if (available_ports[p]) begin
        for (int i = 0; i < `NOC_VCS; i++) begin
          port_req[p].request[i]         = route[i][p] && flit_in_valid[i];
          port_req[p].start_of_packet[i] = route[i][p] && start_of_packet[i];
          port_req[p].end_of_packet[i]   = route[i][p] && end_of_packet[i];
          routed_valid[p][i]             = route[i][p] && flit_in_valid[i];
          routed_flit[p][i]              = flit_marked[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/noc_output_port.sv */
`default_nettype none

`include "noc_settings.svh"

module noc_output_port (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  noc_route_pkg::noc_port_request        port_req,
  input  noc_flit_pkg::noc_flit [`NOC_VCS-1:0]  routed_flit,
  input  logic [`NOC_VCS-1:0]                   routed_valid,
  output logic [`NOC_VCS-1:0]                   grant,
  output logic [`NOC_VCS-1:0]                   vc_ready,
  output noc_flit_pkg::noc_flit                 flit_out,
  output logic                                  flit_out_valid,
  input  logic                                  flit_out_ready
);

  localparam int PTR_W = (`NOC_VCS > 1) ? $clog2(`NOC_VCS) : 1;

  logic [`NOC_VCS-1:0] candidates;
  logic [`NOC_VCS-1:0] grant_next;
  logic [PTR_W-1:0]    pick;
  logic [PTR_W-1:0]    last_q;

  // only VCs opening a packet may claim the port.
  assign candidates = port_req.request & port_req.start_of_packet;

  // round robin from one past the last winner.
  always_comb begin
    int unsigned idx;
    logic        found;
    grant_next = '0;
    pick       = last_q;
    found      = 1'b0;
    for (int k = 1; k <= `NOC_VCS; k++) begin
      idx = (int'(last_q) + k) % `NOC_VCS;
      if (!found && candidates[idx]) begin
        grant_next[idx] = 1'b1;
        pick            = PTR_W'(idx);
        found           = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grant  <= '0;
      last_q <= '0;
    end else if (|grant) begin
      // owner keeps the port through its tail.
      if (|(grant & port_req.end_of_packet)) begin
        grant <= '0;
      end
    end else if (|candidates) begin
      grant  <= grant_next;
      last_q <= pick;
    end
  end

  always_comb begin
    flit_out = '0;
    for (int i = 0; i < `NOC_VCS; i++) begin
      if (grant[i]) begin
        flit_out = routed_flit[i];
      end
    end
  end

  assign flit_out_valid = |(grant & routed_valid);
  assign vc_ready       = grant & {`NOC_VCS{flit_out_ready}};

endmodule

`default_nettype wire

/* hdl/noc_router.sv */
`default_nettype none

`include "noc_settings.svh"

module noc_router #(
  parameter int       X               = 0,
  parameter int       Y               = 0,
  parameter bit [4:0] available_ports = 5'b11111
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  noc_flit_pkg::noc_flit [`NOC_VCS-1:0]   flit_in,
  input  logic [`NOC_VCS-1:0]                    flit_in_valid,
  output logic [`NOC_VCS-1:0]                    flit_in_ready,
  output noc_flit_pkg::noc_flit [4:0]            flit_out,
  output logic [4:0]                             flit_out_valid,
  input  logic [4:0]                             flit_out_ready,
  output logic [4:0][`NOC_VCS-1:0]               flit_out_vc
);

  noc_route_pkg::noc_port_request [4:0]      port_req;
  noc_flit_pkg::noc_flit [4:0][`NOC_VCS-1:0] routed_flit;
  logic [4:0][`NOC_VCS-1:0]                  routed_valid;
  logic [4:0][`NOC_VCS-1:0]                  grant;
  logic [4:0][`NOC_VCS-1:0]                  vc_ready;

  noc_route_selector #(
    .X               (X),
    .Y               (Y),
    .available_ports (available_ports)
  ) u_selector (
    .clk           (clk),
    .rst_n         (rst_n),
    .flit_in       (flit_in),
    .flit_in_valid (flit_in_valid),
    .flit_in_ready (flit_in_ready),
    .port_req      (port_req),
    .routed_flit   (routed_flit),
    .routed_valid  (routed_valid),
    .grant         (grant),
    .vc_ready      (vc_ready)
  );

  for (genvar p = 0; p < noc_route_pkg::NOC_PORTS; p++) begin : g_port
    if (available_ports[p]) begin : g_on
      noc_output_port u_port (
        .clk            (clk),
        .rst_n          (rst_n),
        .port_req       (port_req[p]),
        .routed_flit    (routed_flit[p]),
        .routed_valid   (routed_valid[p]),
        .grant          (grant[p]),
        .vc_ready       (vc_ready[p]),
        .flit_out       (flit_out[p]),
        .flit_out_valid (flit_out_valid[p]),
        .flit_out_ready (flit_out_ready[p])
      );
    end else begin : g_off
      // disabled port stays silent.
      assign grant[p]          = '0;
      assign vc_ready[p]       = '0;
      assign flit_out[p]       = '0;
      assign flit_out_valid[p] = 1'b0;
    end
  end

  assign flit_out_vc = grant;

endmodule

`default_nettype wire

/* test/noc_router_tb.sv */
`default_nettype none

`include "noc_settings.svh"

module noc_router_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int       HOME_X         = 1;
  localparam int       HOME_Y         = 1;
  localparam bit [4:0] PORTS_ON       = 5'b10111;
  localparam int       NUM_PKTS       = 40;
  localparam int       TOTAL_PKTS     = 2 * NUM_PKTS + 4;
  localparam int       TIMEOUT_CYCLES = TOTAL_PKTS * 4 * 8 + 200;

  logic                                        clk;
  logic                                        rst_n;
  noc_flit_pkg::noc_flit [`NOC_VCS-1:0]        flit_in;
  logic [`NOC_VCS-1:0]                         flit_in_valid;
  logic [`NOC_VCS-1:0]                         flit_in_ready;
  noc_flit_pkg::noc_flit [4:0]                 flit_out;
  logic [4:0]                                  flit_out_valid;
  logic [4:0]                                  flit_out_ready;
  logic [4:0][`NOC_VCS-1:0]                    flit_out_vc;

  int                    seed;
  int                    cycles;
  int                    value_errors;
  int                    other_errors;
  noc_flit_pkg::noc_flit exp_q [5*`NOC_VCS][$];
  int                    cur_port [`NOC_VCS];
  int                    lat_port [`NOC_VCS];
  logic [`NOC_VCS-1:0]   fresh;
  logic [`NOC_VCS-1:0]   lat_pend;
  logic [4:0]            owned;
  logic [4:0]            won_before;
  logic [`NOC_VCS-1:0]   owner      [5];
  logic [`NOC_VCS-1:0]   last_win   [5];
  logic [`NOC_VCS-1:0]   last_vc    [5];
  logic [`NOC_VCS-1:0]   last_cand  [5];

  noc_router #(
    .X               (HOME_X),
    .Y               (HOME_Y),
    .available_ports (PORTS_ON)
  ) DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .flit_in        (flit_in),
    .flit_in_valid  (flit_in_valid),
    .flit_in_ready  (flit_in_ready),
    .flit_out       (flit_out),
    .flit_out_valid (flit_out_valid),
    .flit_out_ready (flit_out_ready),
    .flit_out_vc    (flit_out_vc)
  );

  always #2 clk = ~clk;

  // x first, then y; a disabled port falls back to local.
  function automatic int xy_port(input noc_flit_pkg::noc_location d);
    int p;
    if (d.x > HOME_X) p = 0;
    else if (d.x < HOME_X) p = 1;
    else if (d.y > HOME_Y) p = 2;
    else if (d.y < HOME_Y) p = 3;
    else p = 4;
    if (!PORTS_ON[p]) p = 4;
    return p;
  endfunction

  function automatic logic [`NOC_VCS-1:0] onehot_vc(input int v);
    logic [`NOC_VCS-1:0] m;
    m    = '0;
    m[v] = 1'b1;
    return m;
  endfunction

  function automatic int vc_index(input logic [`NOC_VCS-1:0] g);
    int idx;
    idx = -1;
    for (int i = `NOC_VCS - 1; i >= 0; i--) begin
      if (g[i]) idx = i;
    end
    return idx;
  endfunction

  // VCs offering a head flit toward port p this cycle.
  function automatic logic [`NOC_VCS-1:0] head_requests(input int p);
    logic [`NOC_VCS-1:0] m;
    m = '0;
    for (int i = 0; i < `NOC_VCS; i++) begin
      if (flit_in_valid[i] && flit_in[i].head && cur_port[i] == p) m[i] = 1'b1;
    end
    return m;
  endfunction

  // biased toward the home coordinate, still reaching 4..7.
  function automatic logic [`NOC_COORD_W-1:0] random_coord();
    logic [31:0]             r;
    logic [`NOC_COORD_W-1:0] c;
    r = $random(seed);
    if (r[3]) c = r[`NOC_COORD_W-1:0];
    else c = r[1:0] % 2'd3;
    return c;
  endfunction

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    value_errors++;
    $display("ERROR %s: expected %h, actual %h", name, expected, actual);
  endtask

  task automatic report_fault(input string msg);
    other_errors++;
    $display("%s", msg);
  endtask

  task automatic send_packet(input int v, input noc_flit_pkg::noc_location dst,
                             input int len);
    logic [31:0]           r;
    noc_flit_pkg::noc_flit f;
    noc_flit_pkg::noc_flit want;
    for (int k = 0; k < len; k++) begin
      r      = $random(seed);
      f      = r[$bits(noc_flit_pkg::noc_flit)-1:0];
      f.head = (k == 0);
      f.tail = (k == len - 1);
      if (f.head) begin
        f.header.destination         = dst;
        f.header.invalid_destination = 1'b0;
      end
      want = f;
      if (f.head && (dst.x >= `NOC_SIZE_X || dst.y >= `NOC_SIZE_Y)) begin
        want.header.invalid_destination = 1'b1;
      end
      @(negedge clk);
      flit_in[v]       = f;
      flit_in_valid[v] = 1'b1;
      if (f.head) begin
        cur_port[v] = xy_port(dst);
        fresh[v]    = 1'b1;
      end
      exp_q[cur_port[v] * `NOC_VCS + v].push_back(want);
      do @(posedge clk); while (!flit_in_ready[v]);
    end
    @(negedge clk);
    flit_in_valid[v] = 1'b0;
  endtask

  task automatic random_packets(input int v);
    int                        gap;
    int                        len;
    noc_flit_pkg::noc_location dst;
    for (int n = 0; n < NUM_PKTS; n++) begin
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(negedge clk);
      len   = 1 + $unsigned($random(seed)) % 4;
      dst.x = random_coord();
      dst.y = random_coord();
      send_packet(v, dst, len);
    end
  endtask

  always @(negedge clk) begin
    for (int p = 0; p < 5; p++) begin
      flit_out_ready[p] = ($unsigned($random(seed)) % 4) != 0;
    end
  end

  // outputs are read before this edge updates any register.
  always @(posedge clk) begin
    int                    v;
    logic [`NOC_VCS-1:0]   cand;
    noc_flit_pkg::noc_flit want;
    if (rst_n) begin
      for (int u = 0; u < `NOC_VCS; u++) begin
        if (lat_pend[u]) begin
          assert (flit_out_valid[lat_port[u]] && flit_out_vc[lat_port[u]] == onehot_vc(u))
          else report_value("head_latency", onehot_vc(u), flit_out_vc[lat_port[u]]);
          lat_pend[u] = 1'b0;
        end
        if (fresh[u]) begin
          fresh[u] = 1'b0;
          if (flit_out_vc[cur_port[u]] == '0 && head_requests(cur_port[u]) == onehot_vc(u)) begin
            lat_pend[u] = 1'b1;
            lat_port[u] = cur_port[u];
          end
        end
        if (flit_in_valid[u] && flit_in_ready[u]) begin
          assert (flit_out_ready[cur_port[u]] && flit_out_vc[cur_port[u]][u])
          else report_fault($sformatf("VC %0d accepted a flit that port %0d could not take",
                                      u, cur_port[u]));
        end
      end
      assert (!flit_out_valid[3])
      else report_fault("the disabled y_minus port raised flit_out_valid");
      for (int p = 0; p < 5; p++) begin
        cand = head_requests(p);
        if (owned[p]) begin
          assert (flit_out_vc[p] == owner[p])
          else report_value("grant_hold", owner[p], flit_out_vc[p]);
        end
        if (last_vc[p] == '0 && flit_out_vc[p] != '0) begin
          assert (((flit_out_vc[p] & (flit_out_vc[p] - 1'b1)) == '0) &&
                  ((flit_out_vc[p] & ~last_cand[p]) == '0))
          else report_fault($sformatf("port %0d granted VCs %b without a waiting head",
                                      p, flit_out_vc[p]));
          if ((&last_cand[p]) && won_before[p]) begin
            assert (flit_out_vc[p] != last_win[p])
            else report_value("round_robin", last_cand[p] & ~last_win[p], flit_out_vc[p]);
          end
          last_win[p]   = flit_out_vc[p];
          won_before[p] = 1'b1;
        end
        if (flit_out_valid[p] && flit_out_ready[p]) begin
          v = vc_index(flit_out_vc[p]);
          assert (v >= 0)
          else report_fault($sformatf("port %0d moved a flit with no VC granted", p));
          if (v >= 0) begin
            assert (exp_q[p * `NOC_VCS + v].size() != 0)
            else report_fault($sformatf("VC %0d sent a flit on port %0d with none routed there",
                                        v, p));
            if (exp_q[p * `NOC_VCS + v].size() != 0) begin
              want = exp_q[p * `NOC_VCS + v].pop_front();
              if (want.head && want.header.invalid_destination) begin
                assert (flit_out[p] === want)
                else report_value("invalid_destination", want, flit_out[p]);
              end else begin
                assert (flit_out[p] === want)
                else report_value("packet_integrity", want, flit_out[p]);
              end
            end
          end
          if (flit_out[p].head) begin
            owned[p] = 1'b1;
            owner[p] = flit_out_vc[p];
          end
          if (flit_out[p].tail) owned[p] = 1'b0;
        end
        last_vc[p]   = flit_out_vc[p];
        last_cand[p] = cand;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    $display("Something failed");
    $finish;
  end

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    seed           = 14949;
    value_errors   = 0;
    other_errors   = 0;
    flit_in        = '0;
    flit_in_valid  = '0;
    flit_out_ready = '0;
    fresh          = '0;
    lat_pend       = '0;
    owned          = '0;
    won_before     = '0;
    for (int p = 0; p < 5; p++) begin
      owner[p]     = '0;
      last_win[p]  = '0;
      last_vc[p]   = '0;
      last_cand[p] = '0;
    end
    for (int v = 0; v < `NOC_VCS; v++) begin
      cur_port[v] = 4;
      lat_port[v] = 4;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert ({flit_in_ready, flit_out_valid, flit_out_vc} == '0)
    else report_value("reset", 0, {flit_in_ready, flit_out_valid, flit_out_vc});

    // two rounds of simultaneous heads on the local port.
    repeat (2) begin
      fork
        send_packet(0, '{x: 3'd1, y: 3'd0}, 2);
        send_packet(1, '{x: 3'd1, y: 3'd1}, 1);
      join
    end

    fork
      random_packets(0);
      random_packets(1);
    join

    repeat (4) @(negedge clk);
    for (int q = 0; q < 5 * `NOC_VCS; q++) begin
      assert (exp_q[q].size() == 0)
      else report_fault($sformatf("%0d flits for port %0d VC %0d never left the router",
                                  exp_q[q].size(), q / `NOC_VCS, q % `NOC_VCS));
    end
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
hdl/noc_flit_pkg.sv
hdl/noc_route_pkg.sv
hdl/noc_route_selector.sv
hdl/noc_output_port.sv
hdl/noc_router.sv
test/noc_router_tb.sv

/* Bender.yml */
package:
  name: noc_router

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/noc_flit_pkg.sv
      - hdl/noc_route_pkg.sv
      - hdl/noc_route_selector.sv
      - hdl/noc_output_port.sv
      - hdl/noc_router.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/noc_router_tb.sv
